/* Makefile */
# Verilator build and run for the memory front end testbench

TOP       ?= tb_snes_mem_front
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
LOG       ?= sim.log

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_snes_mem_front.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the memory request front end
// Behavioral SDRAM model with CPU and soft CPU channels,
// directed tests for reset, ROM load, ROM reads, work RAM
// and the soft CPU bridge, compare tasks and a timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "snes_mem_consts.svh"

module tb_snes_mem_front
    import snes_mem_pkg::*;
();

    localparam int              TIMEOUT_CYCLES = 4000;   // About twice the test lengths
    localparam logic [22:0]     RV_A  = 23'h010100;
    localparam logic [21:0]     RV_LO = 22'h008080;
    localparam logic [21:0]     RV_HI = 22'h008081;
    localparam logic [21:0]     WRAM_W = {`SNES_WRAM_PREFIX, 16'h0092};

    logic        mclk = 1'b0;
    logic        resetn;
    logic        loading;
    logic [7:0]  loader_byte;
    logic        loader_strb;
    rom_bus_t    rom_bus;
    wram_bus_t   wram_bus;
    rv_cmd_t     rv_cmd;
    logic        busy;
    logic [15:0] cpu_port0 = '0;
    logic [15:0] cpu_port1 = '0;
    logic [15:0] rv_dout = '0;
    logic        rv_ack = 1'b0;
    cpu_req_t    cpu_req;
    rv_mem_req_t rv_mem;
    logic [15:0] rom_q;
    logic [7:0]  wram_q;
    logic [31:0] rv_rdata;
    logic        rv_ready;
    logic        enable;

    // SDRAM model state
    logic [15:0]             mem [logic [`SNES_ADDR_W-2:0]];
    logic                    cpu_tgl = 1'b0;
    logic                    rd_vld = 1'b0;
    cpu_port_e               rd_port = PORT_ROM;
    logic [15:0]             rd_data = '0;
    logic                    rv_wait = 1'b0;
    logic [2:0]              rv_dly = '0;
    rv_mem_req_t             rv_hold = '0;
    logic [31:0]             rng = 32'd45302;
    int                      cpu_wr_cnt = 0;
    int                      cpu_rd_cnt = 0;
    int                      ready_cnt = 0;
    int                      cycles = 0;

    snes_mem_front UUT (.*);

    always #2 mclk = ~mclk;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] mem_rd(input logic [`SNES_ADDR_W-2:0] a);
        if (mem.exists(a))
            return mem[a];
        else
            return 16'h0000;    // Unwritten SDRAM reads as zero
    endfunction

    function automatic logic [15:0] lane_write(input logic [15:0] old, input logic [15:0] din,
                                               input logic [1:0] ds);
        logic [15:0] w;
        w = old;
        if (ds[0])
            w[7:0] = din[7:0];
        if (ds[1])
            w[15:8] = din[15:8];
        return w;
    endfunction

    // Data byte i of the ROM image
    function automatic logic [7:0] rom_byte(input int i);
        return 8'(i * 29 + 53);
    endfunction

    always @(posedge mclk) begin : sdram_model
        if (!resetn) begin
            cpu_tgl <= 1'b0;
            rd_vld  <= 1'b0;
            rv_wait <= 1'b0;
            rv_ack  <= 1'b0;
        end else begin
            rd_vld <= 1'b0;
            if (rd_vld) begin                   // Second cycle after the read toggle
                if (rd_port == PORT_WRAM)
                    cpu_port1 <= rd_data;
                else
                    cpu_port0 <= rd_data;
                cpu_rd_cnt <= cpu_rd_cnt + 1;
            end
            if (cpu_req.req != cpu_tgl) begin
                cpu_tgl <= cpu_req.req;
                if (cpu_req.we) begin
                    mem[cpu_req.addr] = lane_write(mem_rd(cpu_req.addr), cpu_req.din,
                                                   cpu_req.ds);
                    cpu_wr_cnt <= cpu_wr_cnt + 1;
                end else begin
                    rd_vld  <= 1'b1;
                    rd_port <= cpu_req.port;
                    rd_data <= mem_rd(cpu_req.addr);
                end
            end

            // Soft CPU channel answers after 1 to 4 cycles
            if (!rv_wait) begin
                if (rv_mem.req != rv_ack) begin
                    rng = next_rand(rng);
                    rv_hold <= rv_mem;
                    rv_dly  <= {1'b0, rng[1:0]} + 3'd1;
                    rv_wait <= 1'b1;
                end
            end else if (rv_dly > 3'd1) begin
                rv_dly <= rv_dly - 3'd1;
            end else begin
                if (rv_hold.we)
                    mem[rv_hold.addr] = lane_write(mem_rd(rv_hold.addr), rv_hold.din,
                                                   rv_hold.ds);
                else
                    rv_dout <= mem_rd(rv_hold.addr);
                rv_ack  <= rv_hold.req;
                rv_wait <= 1'b0;
            end
        end
    end

    always @(posedge mclk) begin
        if (resetn && rv_ready)
            ready_cnt <= ready_cnt + 1;
    end

    always @(posedge mclk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            stop_run();
        end
    end

    task automatic stop_run;
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s, expected %b, got %b", $time, what, exp, got);
            stop_run();
        end
    endtask

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s, expected %h, got %h", $time, what, exp, got);
            stop_run();
        end
    endtask

    task automatic compare_word(input logic [15:0] got, input logic [15:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s, expected %h, got %h", $time, what, exp, got);
            stop_run();
        end
    endtask

    task automatic compare_rv(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s, expected %h, got %h", $time, what, exp, got);
            stop_run();
        end
    endtask

    // Write data only matters for writes
    task automatic compare_req(input cpu_req_t got, input cpu_req_t exp, input string what);
        if (got.addr !== exp.addr || got.ds !== exp.ds || got.we !== exp.we
            || got.port !== exp.port || (exp.we && got.din !== exp.din)) begin
            $display("ERROR at %0t: %s, expected addr %h ds %b we %b port %0d din %h,",
                     $time, what, exp.addr, exp.ds, exp.we, exp.port, exp.din);
            $display("    got addr %h ds %b we %b port %0d din %h",
                     got.addr, got.ds, got.we, got.port, got.din);
            stop_run();
        end
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge mclk);
    endtask

    task automatic wait_toggle(input logic old);
        @(negedge mclk);
        while (cpu_req.req == old)
            @(negedge mclk);
    endtask

    task automatic wait_reads(input int n);
        while (cpu_rd_cnt < n)
            @(negedge mclk);
    endtask

    task automatic wait_writes(input int n);
        while (cpu_wr_cnt < n)
            @(negedge mclk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge mclk);
        loader_byte <= b;
        loader_strb <= 1'b1;
        @(posedge mclk);
        loader_strb <= 1'b0;
    endtask

    task automatic test_reset;
        @(negedge mclk);
        compare_bit(enable, 1'b0, "enable after reset");
        compare_bit(rv_ready, 1'b0, "rv_ready after reset");
        compare_bit(cpu_req.req, 1'b0, "cpu_req toggle after reset");
        compare_bit(rv_mem.req, 1'b0, "rv_mem toggle after reset");
        compare_bit(UUT.u_rv_bridge.state == RV_IDLE_REQ0, 1'b1, "bridge state after reset");
    endtask

    task automatic test_rom_load;
        int wr0;
        int k;
        wr0 = cpu_wr_cnt;
        @(posedge mclk);
        loading <= 1'b1;
        @(posedge mclk);                        // Loading edge clears the counters
        for (int i = 0; i < `SNES_HEADER_BYTES; i++)
            send_byte(8'hE0 ^ 8'(i));
        for (int i = 0; i < 16; i++)
            send_byte(rom_byte(i));
        wait_writes(wr0 + 8);
        tick(2);
        @(negedge mclk);
        compare_word(16'(cpu_wr_cnt - wr0), 16'd8, "SDRAM writes during ROM load");
        for (int w = 0; w < 8; w++)
            compare_word(mem_rd(22'(w)), {rom_byte(2 * w + 1), rom_byte(2 * w)},
                         "loaded ROM word");

        @(posedge mclk);
        loading <= 1'b0;
        busy    <= 1'b1;
        tick(6);
        @(negedge mclk);
        compare_bit(enable, 1'b0, "enable while memory busy");
        @(posedge mclk);
        busy <= 1'b0;
        k = 0;
        while (!enable && k < 4) begin
            @(negedge mclk);
            k++;
        end
        if (!enable) begin
            $display("enable did not rise after loading ended with memory idle");
            stop_run();
        end
    endtask

    task automatic rom_read(input logic [23:0] a, input logic wd, input logic [15:0] exp);
        cpu_req_t want;
        logic     tgl;
        int       rd0;
        want      = '0;
        want.addr = a[`SNES_ADDR_W-1:1];
        want.ds   = 2'b11;
        want.port = PORT_ROM;
        tgl = cpu_req.req;
        rd0 = cpu_rd_cnt;
        @(posedge mclk);
        rom_bus <= '{addr: a, ce_n: 1'b0, word: wd};
        wait_toggle(tgl);
        compare_req(cpu_req, want, "ROM read request");
        wait_reads(rd0 + 1);
        compare_word(rom_q, exp, "ROM read data");
        @(posedge mclk);
        rom_bus.ce_n <= 1'b1;
    endtask

    task automatic test_rom_read;
        rom_read(24'h000004, 1'b1, {rom_byte(5), rom_byte(4)});
        rom_read(24'h000007, 1'b0, {rom_byte(6), rom_byte(7)});    // Bytes swapped
        rom_read(24'h000008, 1'b0, {rom_byte(9), rom_byte(8)});
    endtask

    function automatic cpu_req_t wram_req(input logic [16:0] a, input logic [7:0] d,
                                          input logic we);
        cpu_req_t r;
        r      = '0;
        r.addr = {`SNES_WRAM_PREFIX, a[16:1]};
        r.din  = {d, d};
        r.ds   = a[0] ? 2'b10 : 2'b01;
        r.we   = we;
        r.port = PORT_WRAM;
        return r;
    endfunction

    task automatic wram_write(input logic [16:0] a, input logic [7:0] d);
        logic tgl;
        int   wr0;
        tgl = cpu_req.req;
        wr0 = cpu_wr_cnt;
        @(posedge mclk);
        wram_bus <= '{addr: a, d: d, ce_n: 1'b0, rd_n: 1'b1, we_n: 1'b0};
        wait_toggle(tgl);
        compare_req(cpu_req, wram_req(a, d, 1'b1), "work-RAM write request");
        wait_writes(wr0 + 1);
        @(posedge mclk);
        wram_bus.ce_n <= 1'b1;
        wram_bus.we_n <= 1'b1;
        tick(1);
    endtask

    task automatic wram_read(input logic [16:0] a, input logic [7:0] exp);
        logic tgl;
        int   rd0;
        tgl = cpu_req.req;
        rd0 = cpu_rd_cnt;
        @(posedge mclk);
        wram_bus <= '{addr: a, d: 8'h00, ce_n: 1'b0, rd_n: 1'b0, we_n: 1'b1};
        wait_toggle(tgl);
        compare_req(cpu_req, wram_req(a, 8'h00, 1'b0), "work-RAM read request");
        wait_reads(rd0 + 1);
        compare_byte(wram_q, exp, "work-RAM read data");
        @(posedge mclk);
        wram_bus.ce_n <= 1'b1;
        wram_bus.rd_n <= 1'b1;
        tick(1);
    endtask

    task automatic test_wram;
        cpu_req_t want;
        logic     tgl;
        int       rd0;
        wram_write(17'h00124, 8'h5A);
        wram_write(17'h00125, 8'hC3);
        @(negedge mclk);
        compare_word(mem_rd(WRAM_W), 16'hC35A, "work-RAM word in SDRAM");
        wram_read(17'h00124, 8'h5A);
        wram_read(17'h00125, 8'hC3);

        // ROM and work RAM trigger on the same edge
        want      = '0;
        want.addr = 22'h000001;
        want.ds   = 2'b11;
        want.port = PORT_ROM;
        tgl = cpu_req.req;
        rd0 = cpu_rd_cnt;
        @(posedge mclk);
        rom_bus  <= '{addr: 24'h000002, ce_n: 1'b0, word: 1'b1};
        wram_bus <= '{addr: 17'h00124, d: 8'h00, ce_n: 1'b0, rd_n: 1'b0, we_n: 1'b1};
        wait_toggle(tgl);
        compare_req(cpu_req, wram_req(17'h00124, 8'h00, 1'b0), "request on a ROM and work-RAM tie");
        wait_toggle(~tgl);
        compare_req(cpu_req, want, "ROM request after the tie");
        wait_reads(rd0 + 2);
        compare_word(rom_q, {rom_byte(3), rom_byte(2)}, "ROM data after the tie");
        compare_byte(wram_q, 8'h5A, "work-RAM data after the tie");
        @(posedge mclk);
        rom_bus.ce_n  <= 1'b1;
        wram_bus.ce_n <= 1'b1;
        wram_bus.rd_n <= 1'b1;
        tick(1);
    endtask

    task automatic rv_access(input logic [31:0] wd, input logic [3:0] ws,
                             input logic [31:0] exp);
        int rdy0;
        rdy0 = ready_cnt;
        @(posedge mclk);
        rv_cmd <= '{valid: 1'b1, addr: RV_A, wdata: wd, wstrb: ws};
        @(negedge mclk);
        while (!rv_ready)
            @(negedge mclk);
        if (ws == 4'b0000)
            compare_rv(rv_rdata, exp, "soft CPU read data");
        @(posedge mclk);
        rv_cmd.valid <= 1'b0;
        tick(3);
        @(negedge mclk);
        compare_word(16'(ready_cnt - rdy0), 16'd1, "rv_ready pulses for one command");
    endtask

    task automatic test_rv_bridge;
        rv_access(32'h1122_3344, 4'b1111, '0);
        compare_word(mem_rd(RV_LO), 16'h3344, "low word after full write");
        compare_word(mem_rd(RV_HI), 16'h1122, "high word after full write");
        rv_access(32'hAAAA_55CC, 4'b0010, '0);              // Lower half only
        compare_word(mem_rd(RV_LO), 16'h5544, "low word after lower-only write");
        compare_word(mem_rd(RV_HI), 16'h1122, "high word after lower-only write");
        rv_access(32'h7788_99BB, 4'b1100, '0);              // Upper half only
        compare_word(mem_rd(RV_LO), 16'h5544, "low word after upper-only write");
        compare_word(mem_rd(RV_HI), 16'h7788, "high word after upper-only write");
        rv_access(32'h0000_0000, 4'b0000, 32'h7788_5544);
    endtask

    initial begin
        resetn      = 1'b0;
        loading     = 1'b0;
        loader_byte = 8'h00;
        loader_strb = 1'b0;
        busy        = 1'b0;
        rom_bus     = '{addr: '0, ce_n: 1'b1, word: 1'b0};
        wram_bus    = '{addr: '0, d: '0, ce_n: 1'b1, rd_n: 1'b1, we_n: 1'b1};
        rv_cmd      = '0;
        repeat (4) @(posedge mclk);
        resetn <= 1'b1;
        test_reset();
        test_rom_load();
        test_rom_read();
        test_wram();
        test_rv_bridge();
        $display("Simulation passed");
        $finish;
    end

endmodule

/* hw/cpu_req_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM CPU channel request generator
// Loader writes, console ROM reads and work-RAM accesses
// merged onto one toggle request, plus read data steering
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "snes_mem_consts.svh"

module cpu_req_gen
    import snes_mem_pkg::*;
(
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    loading,
    input  logic                    loading_rise,
    input  logic                    loader_strb,
    input  logic [7:0]              loader_byte,
    input  logic [`SNES_ADDR_W-1:0] load_addr,
    input  logic [7:0]              prev_byte,
    input  logic                    header_done,
    input  rom_bus_t                rom_bus,
    input  wram_bus_t               wram_bus,
    input  logic [15:0]             cpu_port0,
    input  logic [15:0]             cpu_port1,
    output cpu_req_t                cpu_req,
    output logic [15:0]             rom_q,
    output logic [7:0]              wram_q
);

    logic [`SNES_ADDR_W-1:0]      rom_addr;
    logic [`SNES_ADDR_W-1:0]      rom_last;
    logic                         rom_last_vld;   // Cleared by a new ROM load
    logic [`SNES_WRAM_ADDR_W-1:0] wram_last;
    logic                         wram_rd;
    logic                         wram_wr;
    logic                         wram_rd_r;
    logic                         wram_wr_r;
    logic                         load_trig;
    logic                         rom_trig;
    logic                         wram_trig;

    assign rom_addr = rom_bus.addr[`SNES_ADDR_W-1:0];
    assign wram_rd  = ~wram_bus.ce_n & ~wram_bus.rd_n;
    assign wram_wr  = ~wram_bus.ce_n & ~wram_bus.we_n;

    // Odd load address closes a byte pair
    assign load_trig = loading & loader_strb & header_done & load_addr[0];
    assign rom_trig  = ~loading & ~rom_bus.ce_n & (~rom_last_vld | (rom_addr != rom_last));
    assign wram_trig = (wram_rd & ~wram_rd_r) | (wram_wr & ~wram_wr_r)
                     | (wram_rd & (wram_bus.addr[`SNES_WRAM_ADDR_W-1:1]
                                   != wram_last[`SNES_WRAM_ADDR_W-1:1]));

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            cpu_req      <= '0;
            rom_last     <= '0;
            rom_last_vld <= 1'b0;
            wram_last    <= '0;
            wram_rd_r    <= 1'b0;
            wram_wr_r    <= 1'b0;
        end else begin
            wram_rd_r <= wram_rd;
            wram_wr_r <= wram_wr;
            if (loading_rise)
                rom_last_vld <= 1'b0;

            if (wram_trig) begin                // Work RAM wins a tie with ROM
                wram_last    <= wram_bus.addr;
                cpu_req.addr <= {`SNES_WRAM_PREFIX, wram_bus.addr[`SNES_WRAM_ADDR_W-1:1]};
                cpu_req.din  <= {wram_bus.d, wram_bus.d};
                cpu_req.ds   <= {wram_bus.addr[0], ~wram_bus.addr[0]};
                cpu_req.we   <= wram_wr;
                cpu_req.port <= PORT_WRAM;
                cpu_req.req  <= ~cpu_req.req;
            end else if (load_trig || rom_trig) begin
                cpu_req.addr <= loading ? load_addr[`SNES_ADDR_W-1:1]
                                        : rom_addr[`SNES_ADDR_W-1:1];
                cpu_req.din  <= {loader_byte, prev_byte};   // Low byte first in the image
                cpu_req.ds   <= 2'b11;
                cpu_req.we   <= loading;
                cpu_req.port <= PORT_ROM;
                cpu_req.req  <= ~cpu_req.req;
                if (rom_trig) begin
                    rom_last     <= rom_addr;
                    rom_last_vld <= 1'b1;
                end
            end
        end
    end

    // Byte fetch at an odd address wants the high byte in the low lane
    assign rom_q  = (rom_bus.word || !rom_bus.addr[0]) ? cpu_port0
                                                        : {cpu_port0[7:0], cpu_port0[15:8]};
    assign wram_q = wram_bus.addr[0] ? cpu_port1[15:8] : cpu_port1[7:0];

    a_req_has_lanes: assert property (@(posedge mclk) disable iff (!resetn)
        $changed(cpu_req.req) |-> cpu_req.ds != 2'b00);

endmodule

/* hw/loader_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM loader control
// Header skip counter, load address and byte pairing,
// loaded flag and console run enable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "snes_mem_consts.svh"

module loader_ctrl (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    loading,
    input  logic                    loader_strb,
    input  logic [7:0]              loader_byte,
    input  logic                    busy,
    output logic [`SNES_ADDR_W-1:0] load_addr,
    output logic [7:0]              prev_byte,
    output logic                    header_done,
    output logic                    loading_rise,
    output logic                    enable
);

    localparam int HDR_W = $clog2(`SNES_HEADER_BYTES + 1);

    logic             loading_r;
    logic             loaded;
    logic [HDR_W-1:0] hdr_cnt;

    assign loading_rise = loading & ~loading_r;
    assign header_done  = hdr_cnt == HDR_W'(`SNES_HEADER_BYTES);

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r <= 1'b0;
            loaded    <= 1'b0;
            hdr_cnt   <= '0;
            load_addr <= '0;
            enable    <= 1'b0;
        end else begin
            loading_r <= loading;
            enable    <= loaded & ~busy;     // Console runs once memory is idle
            if (loading_rise) begin
                load_addr <= '0;
                hdr_cnt   <= '0;
                loaded    <= 1'b0;
            end else begin
                if (loading && loader_strb) begin
                    if (!header_done)
                        hdr_cnt <= hdr_cnt + 1'b1;
                    else
                        load_addr <= load_addr + 1'b1;
                end
                if (!loading && loading_r)
                    loaded <= 1'b1;
            end
        end
    end

    // Even byte waits here for its odd partner
    always_ff @(posedge mclk) begin
        if (loading && loader_strb && header_done)
            prev_byte <= loader_byte;
    end

    a_no_addr_in_header: assert property (@(posedge mclk) disable iff (!resetn)
        !header_done && !loading_rise |=> load_addr == $past(load_addr));

endmodule

/* hw/rv_bridge.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Soft CPU memory bridge
// Splits 32-bit accesses into 16-bit SDRAM toggle requests
// with single-half write shortcuts and read word merging
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "snes_mem_consts.svh"

module rv_bridge
    import snes_mem_pkg::*;
(
    input  logic        mclk,
    input  logic        resetn,
    input  rv_cmd_t     rv_cmd,
    input  logic [15:0] rv_dout,
    input  logic        rv_ack,
    output rv_mem_req_t rv_mem,
    output logic [31:0] rv_rdata,
    output logic        rv_ready
);

    rv_state_e   state;
    logic        valid_r;
    logic        pending;       // Valid edge seen while busy
    logic        valid_rise;
    logic        write;
    logic        ack_ok;
    logic [15:0] rv_dout0;

    // One 16-bit half of the current command
    function automatic rv_mem_req_t half_req(input rv_cmd_t cmd, input logic hi,
                                             input logic tgl);
        rv_mem_req_t r;
        r.addr = {cmd.addr[`SNES_ADDR_W-1:2], hi};
        r.din  = hi ? cmd.wdata[31:16] : cmd.wdata[15:0];
        r.we   = cmd.wstrb != 4'b0000;
        if (r.we)
            r.ds = hi ? cmd.wstrb[3:2] : cmd.wstrb[1:0];
        else
            r.ds = 2'b11;
        r.req  = tgl;
        return r;
    endfunction

    assign valid_rise = rv_cmd.valid & ~valid_r;
    assign write      = rv_cmd.wstrb != 4'b0000;
    assign ack_ok     = rv_mem.req == rv_ack;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state    <= RV_IDLE_REQ0;
            rv_mem   <= '0;
            rv_ready <= 1'b0;
            valid_r  <= 1'b0;
            pending  <= 1'b0;
        end else begin
            valid_r  <= rv_cmd.valid;
            rv_ready <= 1'b0;
            if (valid_rise)
                pending <= 1'b1;

            case (state)
                RV_IDLE_REQ0: begin
                    if (pending || valid_rise) begin
                        pending <= 1'b0;
                        if (write && rv_cmd.wstrb[1:0] == 2'b00) begin
                            rv_mem <= half_req(rv_cmd, 1'b1, ~rv_mem.req);  // Upper only
                            state  <= RV_WAIT1;
                        end else begin
                            rv_mem <= half_req(rv_cmd, 1'b0, ~rv_mem.req);
                            state  <= RV_WAIT0_REQ1;
                        end
                    end
                end
                RV_WAIT0_REQ1: begin
                    if (ack_ok) begin
                        if (write && rv_cmd.wstrb[3:2] == 2'b00) begin
                            rv_ready <= 1'b1;                   // Lower only, done
                            state    <= RV_IDLE_REQ0;
                        end else begin
                            rv_mem <= half_req(rv_cmd, 1'b1, ~rv_mem.req);
                            state  <= write ? RV_WAIT1 : RV_DATA0;
                        end
                    end
                end
                RV_DATA0: state <= RV_WAIT1;
                RV_WAIT1: begin
                    if (ack_ok) begin
                        if (write) begin
                            rv_ready <= 1'b1;
                            state    <= RV_IDLE_REQ0;
                        end else begin
                            state <= RV_DATA1;
                        end
                    end
                end
                RV_DATA1: begin
                    rv_ready <= 1'b1;
                    state    <= RV_IDLE_REQ0;
                end
                default: state <= RV_IDLE_REQ0;
            endcase
        end
    end

    // Low word is still on rv_dout one cycle after its ack
    always_ff @(posedge mclk) begin
        if (state == RV_DATA0)
            rv_dout0 <= rv_dout;
    end

    assign rv_rdata = {rv_dout, rv_dout0};

    a_ready_pulse: assert property (@(posedge mclk) disable iff (!resetn)
        rv_ready |=> !rv_ready);

endmodule

/* hw/snes_mem_front.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory request front end top level
// Loader control, CPU channel requests and soft CPU bridge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "snes_mem_consts.svh"

module snes_mem_front
    import snes_mem_pkg::*;
(
    input  logic        mclk,
    input  logic        resetn,
    // ROM loader stream
    input  logic        loading,
    input  logic [7:0]  loader_byte,
    input  logic        loader_strb,
    // Console and soft CPU
    input  rom_bus_t    rom_bus,
    input  wram_bus_t   wram_bus,
    input  rv_cmd_t     rv_cmd,
    // SDRAM controller
    input  logic        busy,
    input  logic [15:0] cpu_port0,
    input  logic [15:0] cpu_port1,
    input  logic [15:0] rv_dout,
    input  logic        rv_ack,
    output cpu_req_t    cpu_req,
    output rv_mem_req_t rv_mem,
    output logic [15:0] rom_q,
    output logic [7:0]  wram_q,
    output logic [31:0] rv_rdata,
    output logic        rv_ready,
    output logic        enable
);

    logic [`SNES_ADDR_W-1:0] load_addr;
    logic [7:0]              prev_byte;
    logic                    header_done;
    logic                    loading_rise;

    loader_ctrl u_loader_ctrl (
        .mclk         (mclk),
        .resetn       (resetn),
        .loading      (loading),
        .loader_strb  (loader_strb),
        .loader_byte  (loader_byte),
        .busy         (busy),
        .load_addr    (load_addr),
        .prev_byte    (prev_byte),
        .header_done  (header_done),
        .loading_rise (loading_rise),
        .enable       (enable)
    );

    cpu_req_gen u_cpu_req_gen (
        .mclk         (mclk),
        .resetn       (resetn),
        .loading      (loading),
        .loading_rise (loading_rise),
        .loader_strb  (loader_strb),
        .loader_byte  (loader_byte),
        .load_addr    (load_addr),
        .prev_byte    (prev_byte),
        .header_done  (header_done),
        .rom_bus      (rom_bus),
        .wram_bus     (wram_bus),
        .cpu_port0    (cpu_port0),
        .cpu_port1    (cpu_port1),
        .cpu_req      (cpu_req),
        .rom_q        (rom_q),
        .wram_q       (wram_q)
    );

    rv_bridge u_rv_bridge (
        .mclk     (mclk),
        .resetn   (resetn),
        .rv_cmd   (rv_cmd),
        .rv_dout  (rv_dout),
        .rv_ack   (rv_ack),
        .rv_mem   (rv_mem),
        .rv_rdata (rv_rdata),
        .rv_ready (rv_ready)
    );

endmodule

/* hw/snes_mem_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory front end types
// Console bus structs, SDRAM request structs,
// read port select and soft CPU bridge state enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "snes_mem_consts.svh"

package snes_mem_pkg;

    typedef enum logic {
        PORT_ROM  = 1'b0,   // Read data on cpu_port0
        PORT_WRAM = 1'b1    // Read data on cpu_port1
    } cpu_port_e;

    typedef enum logic [2:0] {
        RV_IDLE_REQ0,
        RV_WAIT0_REQ1,
        RV_DATA0,
        RV_WAIT1,
        RV_DATA1
    } rv_state_e;

    typedef struct packed {
        logic [`SNES_ROM_BUS_W-1:0] addr;
        logic                       ce_n;
        logic                       word;   // 16-bit fetch
    } rom_bus_t;

    typedef struct packed {
        logic [`SNES_WRAM_ADDR_W-1:0] addr;
        logic [7:0]                   d;
        logic                         ce_n;
        logic                         rd_n;
        logic                         we_n;
    } wram_bus_t;

    typedef struct packed {
        logic [`SNES_ADDR_W-2:0] addr;      // Word address
        logic [15:0]             din;
        logic [1:0]              ds;        // Byte enables, bit 1 is the high byte
        logic                    we;
        cpu_port_e               port;
        logic                    req;       // Toggle
    } cpu_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`SNES_ADDR_W-1:0] addr;
        logic [31:0]             wdata;
        logic [3:0]              wstrb;
    } rv_cmd_t;

    typedef struct packed {
        logic [`SNES_ADDR_W-2:0] addr;
        logic [15:0]             din;
        logic [1:0]              ds;
        logic                    we;
        logic                    req;
    } rv_mem_req_t;

endpackage

/* include/snes_mem_consts.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory front end constants
// SDRAM, work-RAM and console ROM bus address widths
// Loader header length and work-RAM window prefix
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SNES_MEM_CONSTS_SVH
`define SNES_MEM_CONSTS_SVH

// SDRAM byte address, 8 MB
`define SNES_ADDR_W         23

// 128 KB work RAM
`define SNES_WRAM_ADDR_W    17

`define SNES_ROM_BUS_W      24

// Bytes dropped at the start of a ROM image
`define SNES_HEADER_BYTES   64

// Top 128 KB of SDRAM, banks 7E and 7F
`define SNES_WRAM_PREFIX    6'b111111

`endif

/* project.f */
+incdir+include
hw/snes_mem_pkg.sv
hw/loader_ctrl.sv
hw/cpu_req_gen.sv
hw/rv_bridge.sv
hw/snes_mem_front.sv
dv/tb_snes_mem_front.sv
